//--- logic/seq_pkg.sv
/*
 * Shared definitions of the sequential integer core: widths, opcodes,
 * sequencer states, the two-format instruction word and the decode bus
 */
`default_nettype none

package seq_pkg;

	// ==============================
	// Widths and counts
	// ==============================
	localparam int value_width = 32;
	localparam int reg_count = 16;
	localparam int reg_addr_width = $clog2(reg_count);
	localparam int imm_width = 18;
	// The shift-and-add multiplier retires one multiplier bit per step
	localparam int mul_steps = value_width;
	localparam int mul_count_width = $clog2(mul_steps);

	typedef logic [value_width-1:0] value_t;
	typedef logic [31:0] pc_address_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// Every instruction is one 32-bit word
	localparam pc_address_t pc_step = 32'd4;

	// ==============================
	// Encodings
	// ==============================
	typedef enum logic [1:0] {ifetch, decode, execute, writeback} e_seq_state;

	// Codes above op_jal are no-ops that write nothing
	typedef enum logic [3:0] {
		op_add, op_sub, op_and, op_or, op_xor,
		op_addi, op_andi, op_ori, op_mul, op_jal
	} e_opcode;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} e_alu_op;

	// Register format with the second source register
	typedef struct packed {
		e_opcode opcode;
		logic rtn;
		logic bitwise;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		logic [13:0] zero;
	} instr_r_t;

	// Immediate format, the low bits hold a signed constant
	typedef struct packed {
		e_opcode opcode;
		logic rtn;
		logic bitwise;
		reg_addr_t rd;
		reg_addr_t rs1;
		logic signed [imm_width-1:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// Everything execute and writeback need to know about one instruction
	typedef struct packed {
		e_alu_op alu_op;
		logic alu;
		logic mul;
		logic jal;
		logic use_imm;
		logic rtn;
		logic bitwise;
		logic rtz;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		value_t imm;
	} decode_bus_t;

endpackage

`default_nettype wire

//--- logic/seq_if.sv
/*
 * Register read interface, two addresses out and two data words back
 */
`timescale 1ns/100ps
`default_nettype none

interface rf_read_if;

	seq_pkg::reg_addr_t rs1_addr;
	seq_pkg::reg_addr_t rs2_addr;
	seq_pkg::value_t rs1_data;
	seq_pkg::value_t rs2_data;

	// Readers present addresses and see the data in the same cycle
	modport reader(output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);

	// The register file answers combinationally
	modport regfile(input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);

endinterface

`default_nettype wire

//--- logic/seq_control.sv
/*
 * Sequencer control: state register, program counter and the latch that
 * holds the accepted instruction word for the rest of its life
 */
`timescale 1ns/100ps
`default_nettype none

module seq_control (
	input wire logic clk,
	input wire logic rst,
	input wire seq_pkg::instr_u instr,
	input wire logic instr_valid,
	input wire seq_pkg::decode_bus_t db,
	input wire seq_pkg::e_seq_state next_state,
	output seq_pkg::e_seq_state state,
	output logic fetch_req,
	output seq_pkg::pc_address_t pc,
	output seq_pkg::instr_u instr_q,
	output logic mul_start
);

	// The store is asked for a word for as long as the core sits in fetch
	assign fetch_req = (state == seq_pkg::ifetch);

	// Multiply operands are on the read ports during execute
	assign mul_start = (state == seq_pkg::execute) && db.mul;

	// ==============================
	// State and program counter
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seq_pkg::ifetch;
			pc <= '0;
		end else begin
			case (state)
				// A valid strobe is only taken while fetching
				seq_pkg::ifetch: begin
					if (instr_valid)
						state <= seq_pkg::decode;
				end
				seq_pkg::decode: state <= seq_pkg::execute;
				seq_pkg::execute: state <= seq_pkg::writeback;
				seq_pkg::writeback: begin
					// Writeback decides how long it stays
					state <= next_state;
					// The pc moves on only when the instruction retires
					if (next_state == seq_pkg::ifetch) begin
						if (db.jal)
							pc <= pc + db.imm;
						else
							pc <= pc + seq_pkg::pc_step;
					end
				end
				default: state <= seq_pkg::ifetch;
			endcase
		end
	end

	// Instruction latch, loaded on the accepting edge
	always_ff @(posedge clk) begin
		if ((state == seq_pkg::ifetch) && instr_valid)
			instr_q <= instr;
	end

endmodule

`default_nettype wire

//--- logic/seq_decode.sv
/*
 * Instruction decoder, reads the word in its register or immediate view
 * and builds the decode bus
 */
`timescale 1ns/100ps
`default_nettype none

module seq_decode (
	input wire seq_pkg::instr_u instr,
	output seq_pkg::decode_bus_t db
);

	always_comb begin
		db = '0;
		// The fields up to rs1 sit in the same place in both views
		db.rd = instr.r.rd;
		db.rs1 = instr.r.rs1;
		db.rtn = instr.r.rtn;
		db.bitwise = instr.r.bitwise;
		case (instr.r.opcode)
			seq_pkg::op_add: begin db.alu = 1'b1; db.alu_op = seq_pkg::alu_add; end
			seq_pkg::op_sub: begin db.alu = 1'b1; db.alu_op = seq_pkg::alu_sub; end
			seq_pkg::op_and: begin db.alu = 1'b1; db.alu_op = seq_pkg::alu_and; end
			seq_pkg::op_or: begin db.alu = 1'b1; db.alu_op = seq_pkg::alu_or; end
			seq_pkg::op_xor: begin db.alu = 1'b1; db.alu_op = seq_pkg::alu_xor; end
			seq_pkg::op_addi: begin db.alu = 1'b1; db.use_imm = 1'b1; db.alu_op = seq_pkg::alu_add; end
			seq_pkg::op_andi: begin db.alu = 1'b1; db.use_imm = 1'b1; db.alu_op = seq_pkg::alu_and; end
			seq_pkg::op_ori: begin db.alu = 1'b1; db.use_imm = 1'b1; db.alu_op = seq_pkg::alu_or; end
			seq_pkg::op_mul: db.mul = 1'b1;
			// The jump offset travels as the immediate
			seq_pkg::op_jal: begin db.jal = 1'b1; db.use_imm = 1'b1; end
			default: ;
		endcase
		// Immediate forms have no rs2, register forms have no constant
		if (db.use_imm)
			db.imm = {{(seq_pkg::value_width-seq_pkg::imm_width){instr.i.imm[seq_pkg::imm_width-1]}},
				instr.i.imm};
		else
			db.rs2 = instr.r.rs2;
		// No write for r0 or for an opcode that produces nothing
		db.rtz = (db.rd == '0) || !(db.alu || db.mul || db.jal);
	end

endmodule

`default_nettype wire

//--- logic/seq_alu.sv
/*
 * Combinational ALU for the register and immediate forms
 */
`timescale 1ns/100ps
`default_nettype none

module seq_alu (
	input wire seq_pkg::decode_bus_t db,
	rf_read_if.reader rd_port,
	output seq_pkg::value_t alu_res
);

	seq_pkg::value_t opa;
	seq_pkg::value_t opb;

	// First operand is always rs1
	assign opa = rd_port.rs1_data;

	// Second operand is the sign-extended constant for immediate forms
	assign opb = db.use_imm ? db.imm : rd_port.rs2_data;

	always_comb begin
		case (db.alu_op)
			seq_pkg::alu_add: alu_res = opa + opb;
			seq_pkg::alu_sub: alu_res = opa - opb;
			seq_pkg::alu_and: alu_res = opa & opb;
			seq_pkg::alu_or: alu_res = opa | opb;
			seq_pkg::alu_xor: alu_res = opa ^ opb;
			default: alu_res = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/seq_mul.sv
/*
 * Iterative shift-and-add multiplier, one bit per clock, low word kept
 */
`timescale 1ns/100ps
`default_nettype none

module seq_mul (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	rf_read_if.reader rd_port,
	output logic done,
	output seq_pkg::value_t product
);

	logic busy;
	logic [seq_pkg::mul_count_width-1:0] cnt;
	seq_pkg::value_t mcand;
	seq_pkg::value_t mplier;
	seq_pkg::value_t acc;
	seq_pkg::value_t sum;

	// Partial sum of this step; on the last step it is the full product
	assign sum = acc + (mplier[0] ? mcand : '0);
	assign product = sum;
	assign done = busy && (cnt == seq_pkg::mul_count_width'(seq_pkg::mul_steps - 1));

	// Step counter
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (done)
				busy <= 1'b0;
		end
	end

	// Operands are captured from the read ports at the start edge
	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= rd_port.rs1_data;
			mplier <= rd_port.rs2_data;
			acc <= '0;
		end else if (busy) begin
			acc <= sum;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

`default_nettype wire

//--- logic/seq_regfile.sv
/*
 * Register file, sixteen words, two combinational reads and one write,
 * r0 reads as zero
 */
`timescale 1ns/100ps
`default_nettype none

module seq_regfile (
	input wire logic clk,
	input wire logic rst,
	rf_read_if.regfile rd_port,
	input wire logic we,
	input wire seq_pkg::reg_addr_t wr_addr,
	input wire seq_pkg::value_t wr_data
);

	seq_pkg::value_t regs [seq_pkg::reg_count];

	// Writes to r0 are dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < seq_pkg::reg_count; i++)
				regs[i] <= '0;
		end else if (we && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
	assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

endmodule

`default_nettype wire

//--- logic/seq_writeback.sv
/*
 * Writeback stage: picks the result source, applies the negate or
 * complement modifier, raises the write strobe and ends the instruction
 */
`timescale 1ns/100ps
`default_nettype none

module seq_writeback (
	input wire logic clk,
	input wire logic rst,
	input wire seq_pkg::e_seq_state state,
	output seq_pkg::e_seq_state next_state,
	input wire seq_pkg::decode_bus_t db,
	input wire seq_pkg::value_t alu_res,
	input wire seq_pkg::value_t mul_res,
	input wire seq_pkg::pc_address_t pc,
	input wire logic mul_done,
	output logic rfwr,
	output seq_pkg::reg_addr_t rd,
	output seq_pkg::value_t res
);

	// Negate with rtn alone, complement with rtn and bitwise
	function automatic seq_pkg::value_t modify(input seq_pkg::value_t v, input logic rtn,
		input logic bitwise);
		case ({rtn, bitwise})
			2'b10: return -v;
			2'b11: return ~v;
			default: return v;
		endcase
	endfunction

	// ==============================
	// Exit decision
	// ==============================
	// A multiply keeps the core here until the multiplier reports done
	always_comb begin
		next_state = state;
		if (state == seq_pkg::writeback) begin
			if (!db.mul || mul_done)
				next_state = seq_pkg::ifetch;
		end
	end

	// Strobe is a single-cycle pulse after the result is chosen
	always_ff @(posedge clk) begin
		if (rst)
			rfwr <= 1'b0;
		else
			rfwr <= (state == seq_pkg::writeback) && !db.rtz && (db.alu || db.jal || (db.mul && mul_done));
	end

	// Result and destination
	always_ff @(posedge clk) begin
		if (state == seq_pkg::writeback) begin
			rd <= db.rd;
			if (db.alu)
				res <= modify(alu_res, db.rtn, db.bitwise);
			else if (db.jal)
				res <= pc + seq_pkg::pc_step;
			else if (db.mul && mul_done)
				res <= modify(mul_res, db.rtn, db.bitwise);
		end
	end

endmodule

`default_nettype wire

//--- logic/seq_core.sv
/*
 * Sequential integer core top level, four-state sequencer around an ALU,
 * an iterative multiplier and a sixteen-entry register file
 */
`timescale 1ns/100ps
`default_nettype none

module seq_core (
	input wire logic clk,
	input wire logic rst,
	output logic fetch_req,
	output seq_pkg::pc_address_t pc,
	input wire logic [seq_pkg::value_width-1:0] instr,
	input wire logic instr_valid,
	output logic wb_we,
	output seq_pkg::reg_addr_t wb_rd,
	output seq_pkg::value_t wb_data
);

	seq_pkg::e_seq_state state;
	seq_pkg::e_seq_state next_state;
	seq_pkg::instr_u instr_q;
	seq_pkg::decode_bus_t db;
	seq_pkg::value_t alu_res;
	seq_pkg::value_t mul_res;
	logic mul_start;
	logic mul_done;

	rf_read_if rf ();

	// Source registers come straight from the decode bus
	assign rf.rs1_addr = db.rs1;
	assign rf.rs2_addr = db.rs2;

	seq_control u_control (.clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid),
		.db(db), .next_state(next_state), .state(state), .fetch_req(fetch_req), .pc(pc),
		.instr_q(instr_q), .mul_start(mul_start));

	seq_decode u_decode (.instr(instr_q), .db(db));

	seq_alu u_alu (.db(db), .rd_port(rf.reader), .alu_res(alu_res));

	seq_mul u_mul (.clk(clk), .rst(rst), .start(mul_start), .rd_port(rf.reader),
		.done(mul_done), .product(mul_res));

	seq_regfile u_regfile (.clk(clk), .rst(rst), .rd_port(rf.regfile), .we(wb_we),
		.wr_addr(wb_rd), .wr_data(wb_data));

	seq_writeback u_writeback (.clk(clk), .rst(rst), .state(state), .next_state(next_state),
		.db(db), .alu_res(alu_res), .mul_res(mul_res), .pc(pc), .mul_done(mul_done),
		.rfwr(wb_we), .rd(wb_rd), .res(wb_data));

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
/*
 * Testbench clock and reset, 10 ns period with reset held for 16 cycles
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	localparam int half_period = 5;
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// Reset drops just after an edge, like every other driven input
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/seq_core_sva.sv
/*
 * Concurrent checks on the core top level, write strobe shape,
 * r0 protection, fetch request timing and the three-edge ALU latency
 */
`timescale 1ns/100ps
`default_nettype none

module seq_core_sva (
	input wire logic clk,
	input wire logic rst,
	input wire logic fetch_req,
	input wire logic instr_valid,
	input wire logic [31:0] instr,
	input wire seq_pkg::e_seq_state state,
	input wire seq_pkg::e_seq_state next_state,
	input wire logic wb_we,
	input wire seq_pkg::reg_addr_t wb_rd
);

	int fails = 0;
	logic accept_write;
	logic wb_exit;
	logic in_flight;

	// Accepted word that writes a register and is not a multiply
	assign accept_write = fetch_req && instr_valid && (instr[25:22] != '0)
		&& (instr[31:28] <= 4'(seq_pkg::op_jal)) && (instr[31:28] != 4'(seq_pkg::op_mul));

	// Writeback hands the core back to fetch on this cycle
	assign wb_exit = (state == seq_pkg::writeback) && (next_state == seq_pkg::ifetch);

	// An accepted word owns the core until its writeback exits
	always_ff @(posedge clk) begin
		if (rst)
			in_flight <= 1'b0;
		else if (fetch_req && instr_valid)
			in_flight <= 1'b1;
		else if (wb_exit)
			in_flight <= 1'b0;
	end

	// ==============================
	// Properties
	// ==============================
	strobe_single: assert property (@(posedge clk) disable iff (rst) wb_we |=> !wb_we)
	else begin
		$error("write strobe held high for two cycles");
		fails++;
	end

	no_r0_write: assert property (@(posedge clk) disable iff (rst) wb_we |-> (wb_rd != '0))
	else begin
		$error("write strobe aimed at r0");
		fails++;
	end

	// No new word is requested while one is still in flight
	fetch_quiet: assert property (@(posedge clk) disable iff (rst) in_flight |-> !fetch_req)
	else begin
		$error("fetch request raised while an instruction is in flight");
		fails++;
	end

	// The strobe rises on the third edge after acceptance, so it is sampled on the fourth
	alu_latency: assert property (@(posedge clk) disable iff (rst)
		accept_write |=> !wb_we [*3] ##1 wb_we)
	else begin
		$error("write strobe not three edges after acceptance");
		fails++;
	end

endmodule

bind seq_core seq_core_sva sva0 (
	.clk(clk),
	.rst(rst),
	.fetch_req(fetch_req),
	.instr_valid(instr_valid),
	.instr(instr),
	.state(state),
	.next_state(next_state),
	.wb_we(wb_we),
	.wb_rd(wb_rd)
);

`default_nettype wire

//--- verification/tb_seq_core.sv
/*
 * Directed tests for the sequential core, with an instruction store model,
 * a register model of the expected results and a watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module tb_seq_core;

	// ==============================
	// Run limits
	// ==============================
	localparam int clk_period = 10;
	localparam int alu_latency = 3;
	// Execute starts one edge after acceptance and the product lands 33 edges later
	localparam int mul_latency = 1 + 33;
	localparam int max_gap = 3;
	localparam int total_instr = 50;
	localparam int total_mul = 6;
	localparam int max_cycles = 16 + total_instr * (alu_latency + max_gap + 4)
		+ total_mul * 40 + 100;

	logic clk;
	logic rst;
	logic fetch_req;
	logic [31:0] pc;
	logic [31:0] instr;
	logic instr_valid;
	logic wb_we;
	logic [3:0] wb_rd;
	logic [31:0] wb_data;

	logic [31:0] mem [1024];
	logic [31:0] model_regs [16];
	logic [31:0] lfsr_state;
	logic [31:0] exp_pc;
	logic [31:0] build_pc;
	logic gaps_on;
	logic pend_we;
	logic [3:0] pend_rd;
	logic [31:0] pend_data;
	int pend_lat;
	int n_prog;
	int errors;
	int checks;
	int test_err_start;

	tb_clock_gen clock0 (.clk(clk), .rst(rst));

	seq_core dut0 (.clk(clk), .rst(rst), .fetch_req(fetch_req), .pc(pc), .instr(instr),
		.instr_valid(instr_valid), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data));

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [3:0] pick_reg();
		logic [3:0] r;
		r = 4'(take_bits(4));
		return (r == '0) ? 4'd1 : r;
	endfunction

	function automatic logic [31:0] enc_r(input logic [3:0] op, input logic [1:0] mods,
		input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2);
		return {op, mods, rd, rs1, rs2, 14'd0};
	endfunction

	function automatic logic [31:0] enc_i(input logic [3:0] op, input logic [1:0] mods,
		input logic [3:0] rd, input logic [3:0] rs1, input logic [17:0] imm);
		return {op, mods, rd, rs1, imm};
	endfunction

	// Random ALU word, codes 0 to 7 cover every register and immediate form
	function automatic logic [31:0] alu_word(input logic rtn, input logic bw);
		logic [3:0] op;
		op = 4'(take_bits(3));
		if (op >= 4'(seq_pkg::op_addi))
			return enc_i(op, {rtn, bw}, pick_reg(), 4'(take_bits(4)), 18'(take_bits(18)));
		return enc_r(op, {rtn, bw}, pick_reg(), 4'(take_bits(4)), 4'(take_bits(4)));
	endfunction

	// Programs are laid out along the path the pc will take
	task automatic emit(input logic [31:0] w);
		mem[build_pc[11:2]] = w;
		n_prog++;
		if (w[31:28] == 4'(seq_pkg::op_jal))
			build_pc = build_pc + {{14{w[17]}}, w[17:0]};
		else
			build_pc = build_pc + 32'd4;
	endtask

	// ==============================
	// Result model
	// ==============================
	task automatic predict_result(input logic [31:0] w);
		logic [3:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] v;
		logic writes;
		op = w[31:28];
		a = model_regs[w[21:18]];
		b = model_regs[w[17:14]];
		imm = {{14{w[17]}}, w[17:0]};
		v = '0;
		writes = 1'b1;
		pend_lat = alu_latency;
		case (op)
			seq_pkg::op_add: v = a + b;
			seq_pkg::op_sub: v = a - b;
			seq_pkg::op_and: v = a & b;
			seq_pkg::op_or: v = a | b;
			seq_pkg::op_xor: v = a ^ b;
			seq_pkg::op_addi: v = a + imm;
			seq_pkg::op_andi: v = a & imm;
			seq_pkg::op_ori: v = a | imm;
			seq_pkg::op_mul: begin
				v = a * b;
				pend_lat = mul_latency;
			end
			seq_pkg::op_jal: v = exp_pc + 32'd4;
			default: writes = 1'b0;
		endcase
		// The link value never takes the modifier
		if (w[27] && (op != 4'(seq_pkg::op_jal)))
			v = w[26] ? ~v : -v;
		pend_we = writes && (w[25:22] != '0);
		pend_rd = w[25:22];
		pend_data = v;
		if (pend_we)
			model_regs[pend_rd] = v;
		exp_pc = (op == 4'(seq_pkg::op_jal)) ? exp_pc + imm : exp_pc + 32'd4;
	endtask

	// Store model and strobe checker, runs until every word has retired
	task automatic run_program();
		int cyc;
		int accept_cyc;
		int accepted;
		int gap;
		logic in_flight;
		logic seen;
		cyc = 0;
		accept_cyc = 0;
		accepted = 0;
		gap = 0;
		in_flight = 1'b0;
		seen = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			cyc++;
			instr_valid = 1'b0;
			if (wb_we) begin
				checks++;
				assert (in_flight && pend_we && !seen)
				else begin
					$display("a write strobe came that no instruction asked for at %0t", $time);
					errors++;
				end
				if (in_flight && pend_we && !seen) begin
					assert ((wb_rd == pend_rd) && (wb_data == pend_data))
					else begin
						$display("error %0t: wrote r%0d = %h, expected r%0d = %h", $time,
							wb_rd, wb_data, pend_rd, pend_data);
						errors++;
					end
					assert (cyc - accept_cyc == pend_lat)
					else begin
						$display("error %0t: write strobe %0d cycles after acceptance, expected %0d",
							$time, cyc - accept_cyc, pend_lat);
						errors++;
					end
				end
				seen = 1'b1;
			end
			if (fetch_req) begin
				if (in_flight) begin
					checks++;
					assert (seen || !pend_we)
					else begin
						$display("the instruction accepted at %0t never wrote its register", $time);
						errors++;
					end
					in_flight = 1'b0;
				end
				if (accepted == n_prog)
					break;
				if (gap > 0) begin
					gap--;
				end else begin
					checks++;
					assert (pc == exp_pc)
					else begin
						$display("error %0t: fetch from pc %h, expected %h", $time, pc, exp_pc);
						errors++;
					end
					instr = mem[pc[11:2]];
					instr_valid = 1'b1;
					predict_result(instr);
					accept_cyc = cyc + 1;
					accepted++;
					in_flight = 1'b1;
					seen = 1'b0;
					gap = gaps_on ? int'(take_bits(2)) : 0;
				end
			end
		end
	endtask

	task automatic begin_test();
		n_prog = 0;
		build_pc = exp_pc;
		test_err_start = errors;
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_err_start);
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic test_alu_ops();
		begin_test();
		// Seed r1 to r4 with sign-extended constants
		for (int k = 1; k <= 4; k++)
			emit(enc_i(seq_pkg::op_addi, 2'b00, 4'(k), 4'd0, 18'(take_bits(18))));
		repeat (12) emit(alu_word(1'b0, 1'b0));
		run_program();
		end_test("alu_ops");
	endtask

	task automatic test_modifiers();
		begin_test();
		repeat (6) emit(alu_word(1'b1, 1'(take_bits(1))));
		emit(enc_r(seq_pkg::op_mul, 2'b10, pick_reg(), pick_reg(), pick_reg()));
		emit(enc_r(seq_pkg::op_mul, 2'b11, pick_reg(), pick_reg(), pick_reg()));
		run_program();
		end_test("modifiers");
	endtask

	task automatic test_multiply();
		begin_test();
		repeat (4) emit(enc_r(seq_pkg::op_mul, 2'b00, pick_reg(), pick_reg(), pick_reg()));
		run_program();
		end_test("multiply");
	endtask

	task automatic test_jal();
		logic [17:0] offset;
		begin_test();
		// Forward jumps only, so the layout never folds onto itself
		for (int k = 0; k < 3; k++) begin
			offset = 18'(4 * (1 + take_bits(3)));
			emit(enc_i(seq_pkg::op_jal, 2'(k == 0 ? 0 : k + 1), pick_reg(), 4'd0, offset));
			emit(alu_word(1'b0, 1'b0));
		end
		run_program();
		end_test("jal");
	endtask

	task automatic test_reg_zero();
		begin_test();
		emit(enc_i(seq_pkg::op_addi, 2'b00, 4'd0, 4'd0, 18'(take_bits(18))));
		emit(enc_r(seq_pkg::op_add, 2'b00, 4'd0, 4'd1, 4'd2));
		emit(enc_i(seq_pkg::op_jal, 2'b00, 4'd0, 4'd0, 18'd8));
		// Undefined opcode with a live rd
		emit({4'hd, 2'b00, 4'd5, 4'd1, 18'd0});
		emit(enc_r(seq_pkg::op_or, 2'b00, 4'd6, 4'd0, 4'd3));
		emit(enc_i(seq_pkg::op_addi, 2'b10, 4'd7, 4'd0, 18'(take_bits(18))));
		run_program();
		end_test("reg_zero");
	endtask

	task automatic test_fetch_gaps();
		begin_test();
		gaps_on = 1'b1;
		repeat (10) emit(alu_word(1'b0, 1'b0));
		run_program();
		gaps_on = 1'b0;
		end_test("fetch_gaps");
	endtask

	initial begin
		instr = '0;
		instr_valid = 1'b0;
		lfsr_state = 32'hccf5;
		gaps_on = 1'b0;
		exp_pc = '0;
		n_prog = 0;
		errors = 0;
		checks = 0;
		test_err_start = 0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		// Unused words are no-ops tagged with their own address
		for (int i = 0; i < 1024; i++)
			mem[i] = {4'hf, 28'(i)};
		@(negedge rst);
		@(posedge clk);
		#1;
		checks++;
		assert (fetch_req && !wb_we && (pc == '0))
		else begin
			$display("the core did not leave reset fetching from address zero");
			errors++;
		end
		test_alu_ops();
		test_modifiers();
		test_multiply();
		test_jal();
		test_reg_zero();
		test_fetch_gaps();
		errors = errors + dut0.sva0.fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the program lengths above
	initial begin
		#(max_cycles * clk_period);
		$display("watchdog expired after %0d cycles, the core stopped retiring", max_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
logic/seq_pkg.sv
logic/seq_if.sv
logic/seq_control.sv
logic/seq_decode.sv
logic/seq_alu.sv
logic/seq_mul.sv
logic/seq_regfile.sv
logic/seq_writeback.sv
logic/seq_core.sv
verification/tb_clock_gen.sv
verification/seq_core_sva.sv
verification/tb_seq_core.sv
